/* Makefile */
# Verilator build and run of the burst framer testbench

BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module tb_burst_framer -Mdir $(BUILD) -o sim
	./$(BUILD)/sim

clean:
	rm -rf $(BUILD)

/* files.f */
hw/framer_pkg.sv
hw/framer_settings.sv
hw/burst_framer_core.sv
hw/burst_framer.sv
tb/burst_framer_chk.sv
tb/tb_burst_framer.sv

/* hw/burst_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_framer (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     clear,
   input  logic                     set_stb,
   input  framer_pkg::set_addr_t    set_addr,
   input  framer_pkg::set_data_t    set_data,
   input  framer_pkg::sample_beat_t in_beat,
   input  logic                     in_valid,
   output logic                     in_ready,  // doubles as trigger ready
   input  logic                     trig,
   input  logic                     trig_valid,
   output framer_pkg::sample_beat_t out_beat,
   output logic                     out_valid,
   input  logic                     out_ready,
   output logic                     eob
);

   import framer_pkg::*;

   framer_cfg_t cfg;
   logic        short_written;

   framer_settings u_settings (
      .clk           (clk),
      .arst_n        (arst_n),
      .set_stb       (set_stb),
      .set_addr      (set_addr),
      .set_data      (set_data),
      .cfg           (cfg),
      .short_written (short_written)
   );

   burst_framer_core u_core (
      .clk           (clk),
      .arst_n        (arst_n),
      .clear         (clear),
      .cfg           (cfg),
      .short_written (short_written),
      .in_beat       (in_beat),
      .in_valid      (in_valid),
      .trig          (trig),
      .trig_valid    (trig_valid),
      .in_ready      (in_ready),
      .out_beat      (out_beat),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .eob           (eob)
   );

endmodule

`default_nettype wire

/* hw/burst_framer_core.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_framer_core (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     clear,
   input  framer_pkg::framer_cfg_t  cfg,
   input  logic                     short_written,
   input  framer_pkg::sample_beat_t in_beat,
   input  logic                     in_valid,
   input  logic                     trig,
   input  logic                     trig_valid,
   output logic                     in_ready,
   output framer_pkg::sample_beat_t out_beat,
   output logic                     out_valid,
   input  logic                     out_ready,
   output logic                     eob
);

   import framer_pkg::*;

   framer_state_t state;
   count_t        pos;        // 1-based position within current period
   count_t        pos_limit;
   count_t        sym_num;
   count_t        limit;
   logic          first_sym;
   logic          shorten;
   logic          pos_done;
   logic          both_valid;
   logic          consume;
   logic          out_last;

   assign both_valid = in_valid && trig_valid;

   // idle states drop beats regardless of the output side
   assign consume  = both_valid && ((state != FRAME) || out_ready);
   assign in_ready = consume;  // also trig_ready

   always_comb
   begin
      case (state)
         OFFSET:  pos_limit = cfg.offset;
         FRAME:   pos_limit = cfg.frame_len;
         GAP:     pos_limit = cfg.gap_len;
         default: pos_limit = '0;
      endcase
   end

   // a zero length still takes one beat
   assign pos_done = (pos >= pos_limit);

   assign limit = shorten ? cfg.short_symbols : cfg.max_symbols;

   // short count write only counts for the running burst
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         shorten <= 1'b0;
      end
      else if (clear)
      begin
         shorten <= 1'b0;
      end
      else if (short_written)
      begin
         shorten <= 1'b1;
      end
      else if (state == WAIT_TRIG)
      begin
         shorten <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= WAIT_TRIG;
         pos       <= '0;
         first_sym <= 1'b0;
         sym_num   <= '0;
      end
      else if (clear)
      begin
         state     <= WAIT_TRIG;
         pos       <= '0;
         first_sym <= 1'b0;
         sym_num   <= '0;
      end
      else if (consume)
      begin
         case (state)
            WAIT_TRIG:
            begin
               if (trig)
               begin
                  state <= OFFSET;
                  pos   <= count_t'(1);
               end
            end
            OFFSET:
            begin
               if (pos_done)
               begin
                  state     <= FRAME;
                  pos       <= count_t'(1);
                  first_sym <= 1'b1;
                  sym_num   <= count_t'(1);
               end
               else
               begin
                  pos <= pos + count_t'(1);
               end
            end
            FRAME:
            begin
               if (pos_done)
               begin
                  first_sym <= 1'b0;
                  pos       <= count_t'(1);
                  sym_num   <= sym_num + count_t'(1);
                  if (!first_sym)  // symbols 1 and 2 go back to back
                  begin
                     state <= (sym_num >= limit) ? WAIT_TRIG : GAP;
                  end
               end
               else
               begin
                  pos <= pos + count_t'(1);
               end
            end
            GAP:
            begin
               if (pos_done)
               begin
                  state <= FRAME;
                  pos   <= count_t'(1);
               end
               else
               begin
                  pos <= pos + count_t'(1);
               end
            end
            default:
            begin
               state <= WAIT_TRIG;
            end
         endcase
      end
   end

   assign out_valid = both_valid && (state == FRAME);
   assign out_last  = out_valid && pos_done;

   assign out_beat.data = in_beat.data;
   assign out_beat.last = out_last;

   // zero symbol number means no burst seen yet
   assign eob = (sym_num != '0) && (sym_num >= limit);

endmodule

`default_nettype wire

/* hw/framer_pkg.sv */
`default_nettype none

package framer_pkg;

   localparam int SAMPLE_W = 32;

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [15:0]         count_t;     // lengths, counts, symbol number
   typedef logic [7:0]          set_addr_t;
   typedef logic [31:0]         set_data_t;  // low 16 bits stored

   // settings register map
   localparam set_addr_t ADDR_FRAME_LEN     = 8'd0;
   localparam set_addr_t ADDR_GAP_LEN       = 8'd1;
   localparam set_addr_t ADDR_OFFSET        = 8'd2;
   localparam set_addr_t ADDR_MAX_SYMBOLS   = 8'd3;
   localparam set_addr_t ADDR_SHORT_SYMBOLS = 8'd4;

   // one beat on the sample streams
   typedef struct packed {
      sample_t data;
      logic    last;
   } sample_beat_t;

   typedef struct packed {
      count_t frame_len;
      count_t gap_len;
      count_t offset;
      count_t max_symbols;
      count_t short_symbols;  // limit override for the running burst
   } framer_cfg_t;

   typedef enum logic [1:0] {
      WAIT_TRIG = 2'd0,
      OFFSET    = 2'd1,
      FRAME     = 2'd2,
      GAP       = 2'd3
   } framer_state_t;

endpackage

`default_nettype wire

/* hw/framer_settings.sv */
`timescale 1ns/1ps
`default_nettype none

module framer_settings (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    set_stb,
   input  framer_pkg::set_addr_t   set_addr,
   input  framer_pkg::set_data_t   set_data,
   output framer_pkg::framer_cfg_t cfg,
   output logic                    short_written
);

   import framer_pkg::*;

   count_t wr_val;
   logic   short_hit;

   assign wr_val = count_t'(set_data[15:0]);  // upper half dropped

   assign short_hit = set_stb && (set_addr == ADDR_SHORT_SYMBOLS);

   // framing registers, one per address
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cfg <= '0;
      end
      else if (set_stb)
      begin
         case (set_addr)
            ADDR_FRAME_LEN:
            begin
               cfg.frame_len <= wr_val;
            end
            ADDR_GAP_LEN:
            begin
               cfg.gap_len <= wr_val;
            end
            ADDR_OFFSET:
            begin
               cfg.offset <= wr_val;
            end
            ADDR_MAX_SYMBOLS:
            begin
               cfg.max_symbols <= wr_val;
            end
            ADDR_SHORT_SYMBOLS:
            begin
               cfg.short_symbols <= wr_val;
            end
            default:
            begin
               // unknown address, nothing stored
            end
         endcase
      end
   end

   // one cycle pulse, lines up with the new short count
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         short_written <= 1'b0;
      end
      else
      begin
         short_written <= short_hit;
      end
   end

endmodule

`default_nettype wire

/* tb/burst_framer_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_framer_chk (
   input logic                      clk,
   input logic                      arst_n,
   input framer_pkg::framer_state_t state,
   input logic                      in_ready,
   input logic                      out_valid,
   input logic                      out_ready,
   input framer_pkg::sample_beat_t  out_beat
);

   import framer_pkg::*;

   // output only comes out of a frame
   valid_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> (state == FRAME))
      else $error("out_valid high outside FRAME");

   stall_blocks_input: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && !out_ready) |-> !in_ready)  // both inputs held on stall
      else $error("input consumed while output stalled");

   last_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
      out_beat.last |-> out_valid)
      else $error("out_last high without out_valid");

endmodule

bind burst_framer_core burst_framer_chk u_chk (
   .clk       (clk),
   .arst_n    (arst_n),
   .state     (state),
   .in_ready  (in_ready),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_beat  (out_beat)
);

`default_nettype wire

/* tb/tb_burst_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_burst_framer;

   import framer_pkg::*;

   localparam int BEAT_TIMEOUT = 100;
   localparam int WAIT_TIMEOUT = 500;

   typedef struct packed {
      logic fwd;
      logic last;
      logic eob;
   } expect_t;

   logic         clk = 1'b0;
   logic         arst_n;
   logic         clear;
   logic         set_stb;
   set_addr_t    set_addr;
   set_data_t    set_data;
   sample_beat_t in_beat;
   logic         in_valid;
   logic         in_ready;
   logic         trig;
   logic         trig_valid;
   sample_beat_t out_beat;
   logic         out_valid;
   logic         out_ready;
   logic         eob;

   framer_cfg_t  cur_cfg;        // shadow of the written registers
   logic         cur_short;
   int           cur_trig;       // input index of the trigger beat, -1 for none
   int           next_idx;
   int           mon_idx;
   int           fwd_count;
   logic         rand_mode;
   logic         idle_eob_check;
   logic [31:0]  lfsr_state;

   burst_framer u_burst_framer (
      .clk        (clk),
      .arst_n     (arst_n),
      .clear      (clear),
      .set_stb    (set_stb),
      .set_addr   (set_addr),
      .set_data   (set_data),
      .in_beat    (in_beat),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .trig       (trig),
      .trig_valid (trig_valid),
      .out_beat   (out_beat),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .eob        (eob)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
   endfunction

   function automatic logic take_bit();
      lfsr_state = lfsr_next(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic int take_bits(input int n);
      int v;
      int i;
      v = 0;
      for (i = 0; i < n; i++)
      begin
         v = (v << 1) | int'(take_bit());
      end
      return v;
   endfunction

   function automatic int at_least_one(input count_t v);
      return (v == 16'd0) ? 1 : int'(v);
   endfunction

   function automatic int burst_limit(input framer_cfg_t c, input logic short_burst);
      return short_burst ? int'(c.short_symbols) : int'(c.max_symbols);
   endfunction

   function automatic int burst_symbols(input framer_cfg_t c, input logic short_burst);
      int lim;
      lim = burst_limit(c, short_burst);
      return (lim < 2) ? 2 : lim;  // never fewer than two
   endfunction

   // trigger beat, offset, frames and the gaps after frame 2
   function automatic int burst_beats(input framer_cfg_t c, input logic short_burst);
      int nsym;
      nsym = burst_symbols(c, short_burst);
      return 1 + at_least_one(c.offset) + nsym * at_least_one(c.frame_len)
         + (nsym - 2) * at_least_one(c.gap_len);
   endfunction

   // expected treatment of consumed beat idx
   function automatic expect_t ref_beat(input framer_cfg_t c, input logic short_burst,
                                        input int trig_idx, input int idx);
      expect_t e;
      int      p;
      int      k;
      int      fl;
      int      gl;
      e  = '0;
      fl = at_least_one(c.frame_len);
      gl = at_least_one(c.gap_len);
      if (trig_idx < 0 || idx <= trig_idx)
      begin
         return e;
      end
      p = idx - trig_idx - 1 - at_least_one(c.offset);
      if (p < 0)
      begin
         return e;
      end
      for (k = 1; k <= burst_symbols(c, short_burst); k++)
      begin
         if (k >= 3)
         begin
            if (p < gl)
            begin
               return e;
            end
            p = p - gl;
         end
         if (p < fl)
         begin
            e.fwd  = 1'b1;
            e.last = (p == fl - 1);
            e.eob  = (k >= burst_limit(c, short_burst));
            return e;
         end
         p = p - fl;
      end
      return e;  // burst over, back to idle
   endfunction

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_beat(input sample_beat_t got, input sample_beat_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED: out_beat at %0t got data %h last %h, expected data %h last %h",
                  $time, got.data, got.last, exp.data, exp.last);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED: %s at %0t got %h, expected %h", name, $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input count_t got, input count_t exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED: %s at %0t got %h, expected %h", name, $time, got, exp);
         abort_run();
      end
   endtask

   // compare on every presented beat, samples stable at negedge
   always @(negedge clk)
   begin : compare_outputs
      expect_t      e;
      sample_beat_t exp_b;
      if (arst_n && in_valid && trig_valid)
      begin
         e = ref_beat(cur_cfg, cur_short, cur_trig, mon_idx);
         check_flag("out_valid", out_valid, e.fwd);
         check_flag("in_ready", in_ready, !e.fwd || out_ready);  // stall only in a frame
         if (e.fwd)
         begin
            exp_b.data = sample_t'(mon_idx);
            exp_b.last = e.last;
            check_beat(out_beat, exp_b);
            check_flag("eob", eob, e.eob);
         end
         else if (idle_eob_check)
         begin
            check_flag("eob", eob, 1'b0);
         end
         if (in_ready)
         begin
            mon_idx++;
         end
      end
      if (arst_n && out_valid && out_ready)
      begin
         fwd_count++;  // transfers seen on the output
      end
   end

   task automatic write_reg(input set_addr_t addr, input count_t val);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = {16'ha5c3, val};  // upper half is junk
      @(posedge clk);
      #1;
      set_stb  = 1'b0;
   endtask

   task automatic load_cfg(input count_t fl, input count_t gl, input count_t off,
                           input count_t max_sym);
      write_reg(ADDR_FRAME_LEN, fl);
      write_reg(ADDR_GAP_LEN, gl);
      write_reg(ADDR_OFFSET, off);
      write_reg(ADDR_MAX_SYMBOLS, max_sym);
      cur_cfg.frame_len   = fl;
      cur_cfg.gap_len     = gl;
      cur_cfg.offset      = off;
      cur_cfg.max_symbols = max_sym;
   endtask

   task automatic pulse_clear();
      clear = 1'b1;
      @(posedge clk);
      #1;
      clear = 1'b0;
   endtask

   // present beats until n of them are consumed
   task automatic drive_beats(input int n);
      int   taken;
      int   stalled;
      logic took;
      taken   = 0;
      stalled = 0;
      while (taken < n)
      begin
         in_beat.data = sample_t'(next_idx);
         trig         = (next_idx == cur_trig);
         if (rand_mode)
         begin
            in_beat.last = take_bit();  // ignored by the core
            in_valid     = take_bit() | take_bit();
            trig_valid   = take_bit() | take_bit();
            out_ready    = take_bit() | take_bit();
         end
         else
         begin
            in_beat.last = 1'b0;
            in_valid     = 1'b1;
            trig_valid   = 1'b1;
            out_ready    = 1'b1;
         end
         @(negedge clk);
         took = in_valid && trig_valid && in_ready;
         @(posedge clk);
         #1;
         if (took)
         begin
            next_idx++;
            taken++;
            stalled = 0;
         end
         else
         begin
            stalled++;
            if (stalled > BEAT_TIMEOUT)
            begin
               $display("timeout: input beat %0d was never consumed", next_idx);
               abort_run();
            end
         end
      end
      in_valid   = 1'b0;
      trig_valid = 1'b0;
      trig       = 1'b0;
      out_ready  = 1'b1;
   endtask

   task automatic wait_fwd(input int target);
      int cycles;
      cycles = 0;
      while (fwd_count < target)
      begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > WAIT_TIMEOUT)
         begin
            $display("timeout: only %0d of %0d output beats arrived", fwd_count, target);
            abort_run();
         end
      end
   endtask

   // one whole burst, with an optional short count write during frame 1
   task automatic run_burst(input logic do_short, input count_t short_val,
                            input int pre, input int post);
      int base;
      int n_fwd;
      base      = fwd_count;
      cur_short = do_short;
      if (do_short)
      begin
         cur_cfg.short_symbols = short_val;
      end
      cur_trig = next_idx + pre;
      n_fwd    = burst_symbols(cur_cfg, do_short) * at_least_one(cur_cfg.frame_len);
      fork
         drive_beats(pre + burst_beats(cur_cfg, do_short) + post);
         if (do_short)
         begin
            wait_fwd(base + 1);
            write_reg(ADDR_SHORT_SYMBOLS, short_val);
         end
      join
      wait_fwd(base + n_fwd);
      check_count("forwarded beats", count_t'(fwd_count - base), count_t'(n_fwd));
   endtask

   initial
   begin
      int b;
      int base;
      int r_fl;
      int r_gl;
      int r_off;
      int r_max;
      arst_n         = 1'b0;
      clear          = 1'b0;
      set_stb        = 1'b0;
      set_addr       = '0;
      set_data       = '0;
      in_beat        = '0;
      in_valid       = 1'b0;
      trig           = 1'b0;
      trig_valid     = 1'b0;
      out_ready      = 1'b1;
      cur_cfg        = '0;
      cur_short      = 1'b0;
      cur_trig       = -1;
      next_idx       = 0;
      mon_idx        = 0;
      fwd_count      = 0;
      rand_mode      = 1'b0;
      idle_eob_check = 1'b0;
      lfsr_state     = 32'h3798_007a;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;

      // no trigger yet, everything dropped
      idle_eob_check = 1'b1;
      drive_beats(20);
      idle_eob_check = 1'b0;
      check_count("forwarded beats", count_t'(fwd_count), 16'd0);

      load_cfg(16'd8, 16'd3, 16'd5, 16'd4);
      write_reg(8'h09, 16'h0001);  // unmapped
      run_burst(1'b0, 16'd0, 3, 2);

      rand_mode = 1'b1;
      for (b = 0; b < 5; b++)
      begin
         r_fl  = 1 + take_bits(3);
         r_gl  = take_bits(2);
         r_off = take_bits(3);
         r_max = 2 + take_bits(2);
         load_cfg(count_t'(r_fl), count_t'(r_gl), count_t'(r_off), count_t'(r_max));
         run_burst(1'b0, 16'd0, 1 + take_bits(2), 2);
      end
      rand_mode = 1'b0;

      // short count only holds for the burst it lands in
      load_cfg(16'd8, 16'd3, 16'd5, 16'd4);
      run_burst(1'b1, 16'd2, 3, 2);
      run_burst(1'b0, 16'd0, 3, 2);

      load_cfg(16'd1, 16'd0, 16'd0, 16'd3);
      run_burst(1'b0, 16'd0, 2, 2);

      // clear three beats into frame 1
      load_cfg(16'd6, 16'd2, 16'd4, 16'd3);
      base      = fwd_count;
      cur_short = 1'b0;
      cur_trig  = next_idx + 2;
      drive_beats(2 + 1 + 4 + 3);
      check_count("forwarded beats", count_t'(fwd_count - base), 16'd3);
      pulse_clear();
      run_burst(1'b0, 16'd0, 4, 2);

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
